// File: banked_memory.sv
`include "cache_defs.svh"

module banked_memory (
    input  logic             clk,
    input  logic             rst,
    input  logic             rd,
    input  logic             wr,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::word_t  data_in,
    output logic             stall,
    output cache_pkg::word_t  data_out
);

    import cache_pkg::*;

    localparam int BANKS = 4;
    localparam int ROWS  = `MEM_WORDS / BANKS;
    localparam int ROW_W = $clog2(ROWS);
    localparam int CNT_W = $clog2(`BANK_BUSY + 1);

    word_t            bank_mem [BANKS][ROWS];
    logic [CNT_W-1:0] busy     [BANKS];     // cycles left per bank

    logic [1:0]       bank;
    logic [ROW_W-1:0] row;
    logic             accept;
    logic             stage1_valid;
    word_t            stage1_data;

    assign bank   = addr[2:1];              // word interleave
    assign row    = addr[`ADDR_W-1:3];
    assign stall  = (rd || wr) && (busy[bank] != '0);
    assign accept = (rd || wr) && !stall;

    initial begin
        for (int b = 0; b < BANKS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                bank_mem[b][r] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < BANKS; b++) begin
            if (rst) begin
                busy[b] <= '0;
            end else if (accept && (bank == 2'(b))) begin
                busy[b] <= CNT_W'(`BANK_BUSY);
            end else if (busy[b] != '0) begin
                busy[b] <= busy[b] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= accept && rd;
        end
    end

    // two-stage read pipeline whose output holds until the next read returns
    always_ff @(posedge clk) begin
        if (accept && wr) begin
            bank_mem[bank][row] <= data_in;
        end
        if (accept && rd) begin
            stage1_data <= bank_mem[bank][row];
        end
        if (stage1_valid) begin
            data_out <= stage1_data;
        end
    end

endmodule

// File: cache_controller.sv
module cache_controller (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd,
    input  logic              wr,
    input  logic              hit,
    input  logic              valid,
    input  logic              dirty,
    input  logic              mem_stall,
    output logic              comp,
    output logic              cache_write,
    output cache_pkg::offset_t cache_offset,
    output logic              cache_offset_select,
    output logic              cache_data_in_select,
    output logic              tag_select,
    output logic              valid_in,
    output cache_pkg::offset_t mem_offset,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic              cache_hit,
    output logic              stall,
    output logic              done,
    output logic              err,
    output logic              flip_victimway,
    output logic              enable
);

    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // both ways are looked up while idle and during compare
    assign enable = (state == IDLE) || (state == COMPARE_RD) || (state == COMPARE_WR);

    always_comb begin
        comp                 = 1'b0;
        cache_write          = 1'b0;
        cache_offset         = 3'b000;
        cache_offset_select  = 1'b0;    // cpu offset by default
        cache_data_in_select = 1'b0;    // cpu data by default
        tag_select           = 1'b0;
        valid_in             = 1'b0;
        mem_offset           = 3'b000;
        mem_rd               = 1'b0;
        mem_wr               = 1'b0;
        cache_hit            = 1'b0;
        stall                = 1'b1;    // busy unless idle
        done                 = 1'b0;
        err                  = 1'b0;
        flip_victimway       = 1'b0;
        next_state           = IDLE;

        case (state)
            IDLE: begin
                stall = 1'b0;
                if (rd && wr) begin
                    next_state = ERROR;
                end else if (rd) begin
                    next_state = COMPARE_RD;
                end else if (wr) begin
                    next_state = COMPARE_WR;
                end
            end
            COMPARE_RD, COMPARE_WR: begin
                comp           = 1'b1;
                cache_write    = (state == COMPARE_WR);   // write lands only on a hit
                flip_victimway = 1'b1;
                if (hit && valid) begin
                    next_state = HIT_DONE;
                end else if (dirty) begin
                    next_state = WB_0;          // victim must go back first
                end else begin
                    next_state = ALLOC_0;
                end
            end
            ALLOC_0, ALLOC_1: begin
                mem_rd     = 1'b1;
                mem_offset = (state == ALLOC_0) ? 3'b000 : 3'b010;
                if (mem_stall) begin
                    next_state = state;
                end else begin
                    next_state = (state == ALLOC_0) ? ALLOC_1 : ALLOC_2;
                end
            end
            ALLOC_2, ALLOC_3: begin
                mem_rd               = 1'b1;
                mem_offset           = (state == ALLOC_2) ? 3'b100 : 3'b110;
                cache_write          = 1'b1;
                valid_in             = 1'b1;
                cache_offset         = (state == ALLOC_2) ? 3'b000 : 3'b010;
                cache_offset_select  = 1'b1;
                cache_data_in_select = 1'b1;    // word fetched two states ago
                if (mem_stall) begin
                    next_state = state;
                end else begin
                    next_state = (state == ALLOC_2) ? ALLOC_3 : ALLOC_4;
                end
            end
            ALLOC_4: begin
                cache_write          = 1'b1;
                valid_in             = 1'b1;
                cache_offset         = 3'b100;
                cache_offset_select  = 1'b1;
                cache_data_in_select = 1'b1;
                next_state           = ALLOC_5;
            end
            ALLOC_5: begin
                cache_write          = 1'b1;
                valid_in             = 1'b1;
                cache_offset         = 3'b110;
                cache_offset_select  = 1'b1;
                cache_data_in_select = 1'b1;
                next_state           = wr ? ALLOC_6 : MISS_DONE;
            end
            ALLOC_6: begin
                // cpu word goes into the fresh line and marks it dirty
                comp        = 1'b1;
                cache_write = 1'b1;
                valid_in    = 1'b1;
                next_state  = MISS_DONE;
            end
            WB_0, WB_1, WB_2, WB_3: begin
                mem_wr              = 1'b1;
                tag_select          = 1'b1;     // address from the victim tag
                cache_offset_select = 1'b1;
                case (state)
                    WB_0:    cache_offset = 3'b000;
                    WB_1:    cache_offset = 3'b010;
                    WB_2:    cache_offset = 3'b100;
                    default: cache_offset = 3'b110;
                endcase
                mem_offset = cache_offset;
                if (mem_stall) begin
                    next_state = state;
                end else begin
                    case (state)
                        WB_0:    next_state = WB_1;
                        WB_1:    next_state = WB_2;
                        WB_2:    next_state = WB_3;
                        default: next_state = ALLOC_0;
                    endcase
                end
            end
            HIT_DONE: begin
                done       = 1'b1;
                cache_hit  = 1'b1;
                next_state = IDLE;
            end
            MISS_DONE: begin
                done       = 1'b1;
                next_state = IDLE;
            end
            ERROR: begin
                err        = 1'b1;          // one cycle, no done
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// tag in bits 15..11, index in bits 10..3 and byte offset in bits 2..0
`define ADDR_W      16
`define WORD_W      16
`define TAG_W       5
`define INDEX_W     8
`define OFFSET_W    3

// lines per way
`define NUM_SETS    256

// main memory depth in words, spread over four banks
`define MEM_WORDS   32768

// cycles a bank stays busy after it takes an access
`define BANK_BUSY   3

`endif

// File: cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0]   word_t;       // one data word
    typedef logic [`ADDR_W-1:0]   addr_t;       // byte address
    typedef logic [`TAG_W-1:0]    tag_t;
    typedef logic [`INDEX_W-1:0]  index_t;
    typedef logic [`OFFSET_W-1:0] offset_t;     // bits 2..1 pick word and bank

    typedef enum logic [4:0] {
        IDLE       = 5'h00,
        COMPARE_RD = 5'h01,
        COMPARE_WR = 5'h02,
        ALLOC_0    = 5'h03,
        ALLOC_1    = 5'h04,
        ALLOC_2    = 5'h05,
        ALLOC_3    = 5'h06,
        ALLOC_4    = 5'h07,
        ALLOC_5    = 5'h08,
        ALLOC_6    = 5'h09,
        WB_0       = 5'h0a,
        WB_1       = 5'h0b,
        WB_2       = 5'h0c,
        WB_3       = 5'h0d,
        HIT_DONE   = 5'h0e,
        MISS_DONE  = 5'h0f,
        ERROR      = 5'h10
    } ctrl_state_t;

endpackage

// File: cache_way.sv
`include "cache_defs.svh"

module cache_way (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  logic              comp,
    input  logic              write,
    input  logic              valid_in,
    input  cache_pkg::tag_t    tag_in,
    input  cache_pkg::index_t  index,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::word_t   data_in,
    output logic              hit,
    output logic              valid,
    output logic              dirty,
    output cache_pkg::tag_t    tag_out,
    output cache_pkg::word_t   data_out
);

    import cache_pkg::*;

    tag_t              tag_mem  [`NUM_SETS];
    word_t             data_mem [`NUM_SETS][4];   // four words per line
    logic [`NUM_SETS-1:0] valid_bits;
    logic [`NUM_SETS-1:0] dirty_bits;

    logic       fill_we;    // line fill from memory
    logic       cpu_we;     // cpu write on a matching valid line
    logic [1:0] word_sel;

    assign word_sel = offset[2:1];

    assign tag_out  = tag_mem[index];
    assign data_out = data_mem[index][word_sel];
    assign valid    = valid_bits[index];
    assign dirty    = dirty_bits[index];
    assign hit      = comp && (tag_out == tag_in);

    assign fill_we = enable && write && !comp;
    assign cpu_we  = enable && write && comp && hit && valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_we) begin
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= 1'b0;      // fresh copy of memory
        end else if (cpu_we) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index] <= tag_in;
        end
        if (fill_we || cpu_we) begin
            data_mem[index][word_sel] <= data_in;
        end
    end

endmodule

// File: mem_system.sv
`include "cache_defs.svh"

module mem_system (
    input  logic             clk,
    input  logic             rst,
    input  logic             rd,
    input  logic             wr,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::word_t  data_in,
    output cache_pkg::word_t  data_out,
    output logic             done,
    output logic             stall,
    output logic             cache_hit,
    output logic             err
);

    import cache_pkg::*;

    tag_t    cpu_tag, mem_tag, tag0, tag1, victim_tag;
    index_t  index;
    offset_t cpu_offset, ctrl_offset, cache_offset, mem_offset;
    addr_t   mem_addr;
    word_t   cache_data_in, data0, data1, way_data, mem_rdata;

    logic comp, cache_write, cache_offset_select, cache_data_in_select;
    logic tag_select, valid_in, mem_rd, mem_wr, mem_stall;
    logic flip_victimway, enable;
    logic hit0, hit1, valid0, valid1, dirty0, dirty1;
    logic hit, valid, dirty, way_en0, way_en1, use_way1;

    assign cpu_tag    = addr[`ADDR_W-1 -: `TAG_W];
    assign index      = addr[`OFFSET_W +: `INDEX_W];
    assign cpu_offset = addr[`OFFSET_W-1:0];

    assign cache_offset  = cache_offset_select ? ctrl_offset : cpu_offset;
    assign cache_data_in = cache_data_in_select ? mem_rdata : data_in;

    // only one way is enabled outside compare, and that one is read
    assign use_way1   = way_en1 & ~way_en0;
    assign way_data   = use_way1 ? data1 : data0;
    assign victim_tag = use_way1 ? tag1 : tag0;

    assign mem_tag  = tag_select ? victim_tag : cpu_tag;
    assign mem_addr = {mem_tag, index, mem_offset};
    assign data_out = way_data;

    cache_controller ctrl (
        .clk(clk), .rst(rst), .rd(rd), .wr(wr),
        .hit(hit), .valid(valid), .dirty(dirty), .mem_stall(mem_stall),
        .comp(comp), .cache_write(cache_write), .cache_offset(ctrl_offset),
        .cache_offset_select(cache_offset_select),
        .cache_data_in_select(cache_data_in_select),
        .tag_select(tag_select), .valid_in(valid_in), .mem_offset(mem_offset),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .cache_hit(cache_hit), .stall(stall),
        .done(done), .err(err), .flip_victimway(flip_victimway), .enable(enable)
    );

    cache_way way0 (
        .clk(clk), .rst(rst), .enable(way_en0), .comp(comp), .write(cache_write),
        .valid_in(valid_in), .tag_in(cpu_tag), .index(index), .offset(cache_offset),
        .data_in(cache_data_in), .hit(hit0), .valid(valid0), .dirty(dirty0),
        .tag_out(tag0), .data_out(data0)
    );

    cache_way way1 (
        .clk(clk), .rst(rst), .enable(way_en1), .comp(comp), .write(cache_write),
        .valid_in(valid_in), .tag_in(cpu_tag), .index(index), .offset(cache_offset),
        .data_in(cache_data_in), .hit(hit1), .valid(valid1), .dirty(dirty1),
        .tag_out(tag1), .data_out(data1)
    );

    way_select sel (
        .clk(clk), .rst(rst), .flip_victimway(flip_victimway), .enable(enable),
        .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
        .dirty0(dirty0), .dirty1(dirty1), .way_en0(way_en0), .way_en1(way_en1),
        .hit(hit), .valid(valid), .dirty(dirty)
    );

    banked_memory mem (
        .clk(clk), .rst(rst), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr),
        .data_in(way_data),             // victim word on write-back
        .stall(mem_stall), .data_out(mem_rdata)
    );

endmodule

// File: mem_system_input.txt
// columns: op_addr_wdata_expdata_exphit, one 56-bit word per line
// op 1 read, 2 write, 3 read and write together (expects err, no done)
// cold read misses and returns 0, the repeat hits
1_0200_0000_0000_0
1_0200_0000_0000_1
// write miss, then hits on the same line
2_0300_a5a5_a5a5_0
1_0300_0000_a5a5_1
1_0302_0000_0000_1
2_0306_1234_1234_1
1_0306_0000_1234_1
// rd and wr together, then a normal request
3_0300_0000_0000_0
1_0300_0000_a5a5_1
// tags 0 and 1 on index 0x10 fill way 0 then way 1
2_0080_1111_1111_0
2_0880_2222_2222_0
1_0080_0000_1111_1
1_0880_0000_2222_1
// 12 compares so far, victim bit 0, dirty way 0 goes back to memory
1_1080_0000_0000_0
1_0880_0000_2222_1
1_0080_0000_1111_0
// 15 compares, victim bit 1, dirty way 1 goes back
2_1882_3333_3333_0
1_0880_0000_2222_0
1_1882_0000_3333_1
1_1880_0000_0000_1
1_0884_0000_0000_1
1_0080_0000_1111_0
1_0200_0000_0000_1
3_0080_0000_0000_0
1_0080_0000_1111_1

// File: mem_system_properties.sv
module mem_system_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   done,
    input logic                   err,
    input logic                   stall,
    input logic                   mem_rd,
    input logic                   mem_wr,
    input cache_pkg::ctrl_state_t ctrl_state
);

    import cache_pkg::*;

    int failure_count = 0;      // read by the testbench summary

    done_err_excl: assert property (@(posedge clk) disable iff (rst) !(done && err))
        else begin
            $error("done and err are high in the same cycle");
            failure_count++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failure_count++;
        end

    mem_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
        else begin
            $error("memory read and write requested together");
            failure_count++;
        end

    idle_no_stall: assert property (@(posedge clk) disable iff (rst)
                                    (ctrl_state == IDLE) |-> !stall)
        else begin
            $error("stall is high while the controller is idle");
            failure_count++;
        end

endmodule

bind mem_system mem_system_properties props (
    .clk(clk), .rst(rst), .done(done), .err(err), .stall(stall),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .ctrl_state(ctrl.state)
);

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_mem_system -o sim_mem_system

./obj_dir/sim_mem_system +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation status: ok"
else
    echo "simulation status: errors found"
    exit 1
fi

// File: src.f
+incdir+.
cache_pkg.sv
cache_controller.sv
cache_way.sv
way_select.sv
banked_memory.sv
mem_system.sv
mem_system_properties.sv
tb_mem_system.sv

// File: tb_mem_system.sv
module tb_mem_system;

    import cache_pkg::*;

    localparam int MAX_VECTORS       = 64;
    localparam int CYCLES_PER_VECTOR = 40;

    logic  clk;
    logic  rst;
    logic  rd;
    logic  wr;
    addr_t addr;
    word_t data_in;
    word_t data_out;
    logic  done;
    logic  stall;
    logic  cache_hit;
    logic  err;

    logic [55:0] vectors [MAX_VECTORS];     // op, addr, write data, expected data, expected hit
    int          num_vectors;
    int          error_count;
    logic        vectors_loaded;

    mem_system UUT (
        .clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
        .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit),
        .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h1:    return "read ";
            4'h2:    return "write";
            4'h3:    return "both ";
            default: return "bad  ";
        endcase
    endfunction

    // issue one request on the rising edge, then watch the falling edges
    task automatic run_request(input int n);
        logic [3:0] op;
        addr_t      req_addr;
        word_t      req_data;
        word_t      exp_data;
        logic       exp_hit;
        int         cycles;
        int         errors_before;
        op            = vectors[n][55:52];
        req_addr      = vectors[n][51:36];
        req_data      = vectors[n][35:20];
        exp_data      = vectors[n][19:4];
        exp_hit       = vectors[n][0];
        errors_before = error_count;
        cycles        = 0;
        if (op > 4'h3) begin
            $display("vector %0d has an unknown operation code %0h", n, op);
            error_count++;
        end else begin
            @(posedge clk);
            rd      <= op[0];
            wr      <= op[1];
            addr    <= req_addr;
            data_in <= req_data;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles == 1) begin
                    compare_value("stall", 32'd0, 32'(stall));    // request seen in idle
                end else if (!done && !err) begin
                    compare_value("stall", 32'd1, 32'(stall));
                end
            end while (!done && !err);
            if (op == 4'h3) begin
                compare_value("err", 32'd1, 32'(err));    // no done on a bad request
                compare_value("done", 32'd0, 32'(done));
            end else begin
                compare_value("err", 32'd0, 32'(err));
                compare_value("data_out", 32'(exp_data), 32'(data_out));
                compare_value("cache_hit", 32'(exp_hit), 32'(cache_hit));
                if (exp_hit) begin
                    compare_value("done latency", 32'd2, 32'(cycles - 1));   // idle + compare
                end
            end
        end
        $display("test %0d %s addr %h: %s", n, op_name(op), req_addr,
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst            = 1'b1;
        rd             = 1'b0;
        wr             = 1'b0;
        addr           = '0;
        data_in        = '0;
        error_count    = 0;
        num_vectors    = 0;
        vectors_loaded = 1'b0;
        for (int i = 0; i < MAX_VECTORS; i++) begin
            vectors[i] = '0;
        end
        $readmemh("mem_system_input.txt", vectors);
        while (num_vectors < MAX_VECTORS && vectors[num_vectors][55:52] != 4'h0) begin
            num_vectors++;      // list ends at the first empty entry
        end
        vectors_loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        if (num_vectors == 0) begin
            $display("no request vectors were read from mem_system_input.txt");
            error_count++;
        end
        for (int n = 0; n < num_vectors; n++) begin
            run_request(n);
        end
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        repeat (2) @(posedge clk);
        $display("%0d requests, %0d mismatches, %0d assertion failures",
                 num_vectors, error_count, UUT.props.failure_count);
        if (error_count == 0 && UUT.props.failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // the slowest request, a dirty miss, ends well inside this budget
    initial begin
        wait (vectors_loaded);
        repeat ((num_vectors + 1) * CYCLES_PER_VECTOR) @(posedge clk);
        $display("timeout: requests did not finish within %0d cycles",
                 (num_vectors + 1) * CYCLES_PER_VECTOR);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: way_select.sv
module way_select (
    input  logic clk,
    input  logic rst,
    input  logic flip_victimway,
    input  logic enable,
    input  logic hit0,
    input  logic hit1,
    input  logic valid0,
    input  logic valid1,
    input  logic dirty0,
    input  logic dirty1,
    output logic way_en0,
    output logic way_en1,
    output logic hit,
    output logic valid,
    output logic dirty
);

    logic victim_bit;   // toggles on every compare
    logic held_way;     // way chosen at the last compare
    logic hit_way0;
    logic hit_way1;
    logic pick;         // victim candidate
    logic sel;

    assign hit_way0 = hit0 & valid0;
    assign hit_way1 = hit1 & valid1;

    // an empty way wins, way 0 first, else the victim bit decides
    assign pick = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : victim_bit);

    assign sel = !enable ? held_way :
                 (hit_way0 | hit_way1) ? hit_way1 : pick;

    assign way_en0 = enable | ~held_way;
    assign way_en1 = enable | held_way;

    assign hit   = sel ? hit1 : hit0;
    assign valid = sel ? valid1 : valid0;
    assign dirty = sel ? (dirty1 & valid1) : (dirty0 & valid0);

    always_ff @(posedge clk) begin
        if (rst) begin
            victim_bit <= 1'b0;
            held_way   <= 1'b0;
        end else if (flip_victimway) begin
            victim_bit <= ~victim_bit;
            held_way   <= sel;          // kept through the whole miss
        end
    end

endmodule
